// File: flist.f
+incdir+include
hdl/tdc_pkg.sv
hdl/tdc_sw_interface.sv
hdl/tdc_input_timer.sv
hdl/tdc_ctrl_fsm.sv
hdl/tdc_word_builder.sv
hdl/tdc_fifo.sv
hdl/tdl_tdc.sv
test/tb_tdl_tdc.sv

// File: hdl/tdc_ctrl_fsm.sv
// --------------------------------------------------
// TDC control FSM
// accepts or rejects pulses and steps through the
// optional timestamp and distance words
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tdc_ctrl_fsm (
	input wire BUS_CLK,
	input wire bus_clk_rst,
	input wire tdc_rst,
	input wire en_tdc,
	input wire en_arm_mode,
	input wire en_trig_distance,
	input wire en_write_timestamp,
	input wire en_no_trig_err,
	input wire arm_pulse,
	input wire sig_rise,
	input wire sig_fall,
	input wire trig_seen,
	output logic word_valid,
	output tdc_pkg::tdc_word_kind_e word_kind,
	output logic event_done,
	output logic miss_pulse
);

	tdc_pkg::tdc_state_e state;
	tdc_pkg::tdc_state_e next_state;
	logic armed;
	logic accept;
	logic emitting;

	// in arm mode only one pulse per arm gets through
	assign accept = en_tdc && (!en_arm_mode || armed);
	assign emitting = (state == tdc_pkg::EMIT_TS) || (state == tdc_pkg::EMIT_DIST) ||
		(state == tdc_pkg::EMIT_WIDTH);

	always_ff @(posedge BUS_CLK) begin
		if (bus_clk_rst || tdc_rst) begin
			state <= tdc_pkg::IDLE;
			armed <= 1'b0;
		end else begin
			state <= next_state;
			if (state == tdc_pkg::IDLE && sig_rise && accept && en_arm_mode) begin
				armed <= 1'b0;
			end else if (arm_pulse) begin
				armed <= 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			tdc_pkg::IDLE: begin
				if (sig_rise && accept) begin
					next_state = tdc_pkg::MEASURE;
				end
			end
			tdc_pkg::MEASURE: begin
				if (sig_fall) begin
					if (en_write_timestamp) begin
						next_state = tdc_pkg::EMIT_TS;
					end else if (en_trig_distance) begin
						next_state = tdc_pkg::EMIT_DIST;
					end else begin
						next_state = tdc_pkg::EMIT_WIDTH;
					end
				end
			end
			tdc_pkg::EMIT_TS: begin
				next_state = en_trig_distance ? tdc_pkg::EMIT_DIST : tdc_pkg::EMIT_WIDTH;
			end
			tdc_pkg::EMIT_DIST: next_state = tdc_pkg::EMIT_WIDTH;
			default: next_state = tdc_pkg::IDLE;
		endcase
	end

	// one word per emit state, the missing-trigger word may be suppressed
	always_comb begin
		word_kind = tdc_pkg::WORD_WIDTH;
		word_valid = emitting;
		case (state)
			tdc_pkg::EMIT_TS: word_kind = tdc_pkg::WORD_TIMESTAMP;
			tdc_pkg::EMIT_DIST: begin
				word_kind = trig_seen ? tdc_pkg::WORD_TRIG_DIST : tdc_pkg::WORD_NO_TRIG;
				word_valid = trig_seen || !en_no_trig_err;
			end
			default: word_kind = tdc_pkg::WORD_WIDTH;
		endcase
	end

	assign event_done = (state == tdc_pkg::EMIT_WIDTH);
	assign miss_pulse = sig_rise && en_tdc &&
		((state == tdc_pkg::IDLE && en_arm_mode && !armed) || emitting);

endmodule

`default_nettype wire

// File: hdl/tdc_fifo.sv
// --------------------------------------------------
// TDC output FIFO
// show-ahead synchronous FIFO, drops words when full
// and counts them
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "tdc_settings.svh"

module tdc_fifo (
	input wire BUS_CLK,
	input wire bus_clk_rst,
	input wire tdc_rst,
	input wire fifo_write,
	input wire [31:0] fifo_wdata,
	input wire fifo_read,
	output logic [31:0] fifo_data,
	output logic fifo_empty,
	output logic [7:0] lost_cnt
);

	logic [31:0] mem [`TDC_FIFO_DEPTH];
	logic [`TDC_FIFO_AW-1:0] wr_ptr;
	logic [`TDC_FIFO_AW-1:0] rd_ptr;
	logic [`TDC_FIFO_AW:0] count;
	logic full;
	logic do_write;
	logic do_read;

	assign full = (count == `TDC_FIFO_DEPTH);
	assign fifo_empty = (count == '0);
	assign do_write = fifo_write && !full;
	assign do_read = fifo_read && !fifo_empty;
	// head word is visible without a read
	assign fifo_data = mem[rd_ptr];

	always_ff @(posedge BUS_CLK) begin
		if (do_write) begin
			mem[wr_ptr] <= fifo_wdata;
		end
	end

	always_ff @(posedge BUS_CLK) begin
		if (bus_clk_rst || tdc_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			lost_cnt <= 8'd0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_write && !do_read) begin
				count <= count + 1'b1;
			end else if (do_read && !do_write) begin
				count <= count - 1'b1;
			end
			if (fifo_write && full && lost_cnt != 8'hFF) begin
				lost_cnt <= lost_cnt + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/tdc_input_timer.sv
// --------------------------------------------------
// TDC input timer
// synchronizes signal and trigger, finds edges and
// counts pulse width and trigger distance
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tdc_input_timer (
	input wire BUS_CLK,
	input wire bus_clk_rst,
	input wire tdc_rst,
	input wire tdc_in,
	input wire trig_in,
	input wire inv_sig,
	input wire inv_trig,
	input wire [15:0] timestamp,
	output logic sig_rise,
	output logic sig_fall,
	output logic [15:0] width_cnt,
	output logic [15:0] trig_dist,
	output logic trig_seen,
	output logic [15:0] ts_capture
);

	logic rst_all;
	logic [1:0] sig_sync;
	logic [1:0] trig_sync;
	logic sig_prev;
	logic trig_prev;
	logic trig_rise;
	logic trig_pend;
	logic [15:0] dist_cnt;

	assign rst_all = bus_clk_rst | tdc_rst;

	// inversion sits in front of the synchronizers
	always_ff @(posedge BUS_CLK) begin
		if (rst_all) begin
			sig_sync <= 2'b00;
			trig_sync <= 2'b00;
			sig_prev <= 1'b0;
			trig_prev <= 1'b0;
			width_cnt <= 16'd0;
			dist_cnt <= 16'd0;
			trig_pend <= 1'b0;
			trig_seen <= 1'b0;
		end else begin
			sig_sync <= {sig_sync[0], tdc_in ^ inv_sig};
			trig_sync <= {trig_sync[0], trig_in ^ inv_trig};
			sig_prev <= sig_sync[1];
			trig_prev <= trig_sync[1];
			// width counts every high cycle from the rise on
			if (sig_rise) begin
				width_cnt <= 16'd1;
			end else if (sig_sync[1] && width_cnt != 16'hFFFF) begin
				width_cnt <= width_cnt + 16'd1;
			end
			if (trig_rise) begin
				dist_cnt <= 16'd1;
			end else if (dist_cnt != 16'hFFFF) begin
				dist_cnt <= dist_cnt + 16'd1;
			end
			// a trigger is pending until the next signal rise takes it
			if (trig_rise) begin
				trig_pend <= 1'b1;
			end else if (sig_rise) begin
				trig_pend <= 1'b0;
			end
			if (sig_rise) begin
				trig_seen <= trig_pend | trig_rise;
			end
		end
	end

	// held values for the word builder
	always_ff @(posedge BUS_CLK) begin
		if (sig_rise) begin
			trig_dist <= trig_rise ? 16'd0 : dist_cnt;
			ts_capture <= timestamp;
		end
	end

	assign sig_rise = sig_sync[1] & ~sig_prev;
	assign sig_fall = ~sig_sync[1] & sig_prev;
	assign trig_rise = trig_sync[1] & ~trig_prev;

endmodule

`default_nettype wire

// File: hdl/tdc_pkg.sv
// --------------------------------------------------
// TDC types
// measurement states, output word kinds and the
// register map offsets
// --------------------------------------------------
`default_nettype none

package tdc_pkg;

	typedef enum logic [2:0] {
		IDLE,
		MEASURE,
		EMIT_TS,
		EMIT_DIST,
		EMIT_WIDTH
	} tdc_state_e;

	// kind field of every output word
	typedef enum logic [1:0] {
		WORD_WIDTH = 2'd0,
		WORD_TRIG_DIST = 2'd1,
		WORD_TIMESTAMP = 2'd2,
		WORD_NO_TRIG = 2'd3
	} tdc_word_kind_e;

	// offsets from the base address
	typedef enum logic [3:0] {
		REG_RESET = 4'd0,
		REG_VERSION = 4'd1,
		REG_CONFIG = 4'd2,
		REG_ARM = 4'd3,
		REG_EVENT0 = 4'd4,
		REG_EVENT1 = 4'd5,
		REG_EVENT2 = 4'd6,
		REG_EVENT3 = 4'd7,
		REG_MISS = 4'd8,
		REG_LOST = 4'd9
	} tdc_reg_e;

endpackage

`default_nettype wire

// File: hdl/tdc_sw_interface.sv
// --------------------------------------------------
// TDC register file
// byte-wide register decode with configuration,
// arm and soft reset strobes and counter readback
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "tdc_settings.svh"

module tdc_sw_interface (
	input wire BUS_CLK,
	input wire bus_clk_rst,
	input wire [`TDC_ABUSWIDTH-1:0] bus_add,
	input wire [7:0] bus_wdata,
	input wire bus_wr,
	input wire bus_rd,
	input wire ext_en,
	input wire ext_arm,
	input wire [31:0] event_count,
	input wire [7:0] miss_cnt,
	input wire [7:0] lost_cnt,
	output logic [7:0] bus_rdata,
	output logic en_tdc,
	output logic en_arm_mode,
	output logic en_trig_distance,
	output logic en_write_timestamp,
	output logic en_no_trig_err,
	output logic inv_sig,
	output logic inv_trig,
	output logic arm_pulse,
	output logic tdc_rst
);

	logic [`TDC_ABUSWIDTH-1:0] rel_add;
	logic in_range;
	logic wr_hit;
	tdc_pkg::tdc_reg_e reg_sel;
	logic [7:0] config_reg;
	logic [7:0] rd_mux;

	// decode relative to the base, only the low nibble selects
	assign rel_add = bus_add - `TDC_BASEADDR;
	assign in_range = (rel_add[`TDC_ABUSWIDTH-1:4] == '0);
	assign reg_sel = tdc_pkg::tdc_reg_e'(rel_add[3:0]);
	assign wr_hit = bus_wr && in_range;

	// --------------------------------------------------
	// writes and strobes
	// --------------------------------------------------
	always_ff @(posedge BUS_CLK) begin
		if (bus_clk_rst) begin
			config_reg <= 8'd0;
			arm_pulse <= 1'b0;
			tdc_rst <= 1'b0;
		end else begin
			arm_pulse <= ext_arm || (wr_hit && reg_sel == tdc_pkg::REG_ARM);
			tdc_rst <= wr_hit && reg_sel == tdc_pkg::REG_RESET;
			if (wr_hit && reg_sel == tdc_pkg::REG_CONFIG) begin
				config_reg <= bus_wdata;
			end
		end
	end

	// external enable can run the block without a config write
	assign en_tdc = config_reg[`TDC_CFG_EN] | ext_en;
	assign en_arm_mode = config_reg[`TDC_CFG_ARM];
	assign en_trig_distance = config_reg[`TDC_CFG_DIST];
	assign en_write_timestamp = config_reg[`TDC_CFG_TS];
	assign inv_sig = config_reg[`TDC_CFG_INV_SIG];
	assign inv_trig = config_reg[`TDC_CFG_INV_TRIG];
	assign en_no_trig_err = config_reg[`TDC_CFG_NO_TRIG_ERR];

	// --------------------------------------------------
	// readback
	// --------------------------------------------------
	always_comb begin
		rd_mux = 8'd0;
		if (in_range) begin
			case (reg_sel)
				tdc_pkg::REG_VERSION: rd_mux = `TDC_VERSION;
				tdc_pkg::REG_CONFIG: rd_mux = config_reg;
				tdc_pkg::REG_EVENT0: rd_mux = event_count[7:0];
				tdc_pkg::REG_EVENT1: rd_mux = event_count[15:8];
				tdc_pkg::REG_EVENT2: rd_mux = event_count[23:16];
				tdc_pkg::REG_EVENT3: rd_mux = event_count[31:24];
				tdc_pkg::REG_MISS: rd_mux = miss_cnt;
				tdc_pkg::REG_LOST: rd_mux = lost_cnt;
				default: rd_mux = 8'd0;
			endcase
		end
	end

	// data is valid the cycle after bus_rd
	always_ff @(posedge BUS_CLK) begin
		if (bus_clk_rst) begin
			bus_rdata <= 8'd0;
		end else if (bus_rd) begin
			bus_rdata <= rd_mux;
		end
	end

endmodule

`default_nettype wire

// File: hdl/tdc_word_builder.sv
// --------------------------------------------------
// TDC word builder
// packs tagged 32-bit words and keeps the event and
// miss counters
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "tdc_settings.svh"

module tdc_word_builder (
	input wire BUS_CLK,
	input wire bus_clk_rst,
	input wire tdc_rst,
	input wire word_valid,
	input wire tdc_pkg::tdc_word_kind_e word_kind,
	input wire event_done,
	input wire miss_pulse,
	input wire [15:0] width_cnt,
	input wire [15:0] trig_dist,
	input wire [15:0] ts_capture,
	output logic fifo_write,
	output logic [31:0] fifo_wdata,
	output logic [31:0] event_count,
	output logic [7:0] miss_cnt
);

	logic [15:0] value;

	always_comb begin
		case (word_kind)
			tdc_pkg::WORD_WIDTH: value = width_cnt;
			tdc_pkg::WORD_TRIG_DIST: value = trig_dist;
			tdc_pkg::WORD_TIMESTAMP: value = ts_capture;
			default: value = 16'd0;
		endcase
	end

	always_comb begin
		fifo_wdata = 32'd0;
		fifo_wdata[`TDC_ID_MSB:`TDC_ID_LSB] = `TDC_DATA_IDENTIFIER;
		fifo_wdata[`TDC_KIND_MSB:`TDC_KIND_LSB] = word_kind;
		// the event counter only moves on after the width word
		fifo_wdata[`TDC_EVENT_MSB:`TDC_EVENT_LSB] = event_count[9:0];
		fifo_wdata[`TDC_VALUE_MSB:`TDC_VALUE_LSB] = value;
	end

	assign fifo_write = word_valid;

	// --------------------------------------------------
	// counters
	// --------------------------------------------------
	always_ff @(posedge BUS_CLK) begin
		if (bus_clk_rst || tdc_rst) begin
			event_count <= 32'd0;
			miss_cnt <= 8'd0;
		end else begin
			if (event_done) begin
				event_count <= event_count + 32'd1;
			end
			if (miss_pulse && miss_cnt != 8'hFF) begin
				miss_cnt <= miss_cnt + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/tdl_tdc.sv
// --------------------------------------------------
// TDC top level
// register file, input timer, control FSM, word
// builder and output FIFO on one clock
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "tdc_settings.svh"

module tdl_tdc (
	input wire BUS_CLK,
	input wire bus_clk_rst,
	input wire [`TDC_ABUSWIDTH-1:0] bus_add,
	input wire [7:0] bus_wdata,
	output wire [7:0] bus_rdata,
	input wire bus_wr,
	input wire bus_rd,
	input wire tdc_in,
	input wire trig_in,
	input wire [15:0] timestamp,
	input wire ext_arm,
	input wire ext_en,
	input wire fifo_read,
	output wire fifo_empty,
	output wire [31:0] fifo_data
);

	// configuration levels and strobes
	wire en_tdc;
	wire en_arm_mode;
	wire en_trig_distance;
	wire en_write_timestamp;
	wire en_no_trig_err;
	wire inv_sig;
	wire inv_trig;
	wire arm_pulse;
	wire tdc_rst;

	// timer results
	wire sig_rise;
	wire sig_fall;
	wire [15:0] width_cnt;
	wire [15:0] trig_dist;
	wire trig_seen;
	wire [15:0] ts_capture;

	// word path and counters
	wire word_valid;
	tdc_pkg::tdc_word_kind_e word_kind;
	wire event_done;
	wire miss_pulse;
	wire fifo_write;
	wire [31:0] fifo_wdata;
	wire [31:0] event_count;
	wire [7:0] miss_cnt;
	wire [7:0] lost_cnt;

	tdc_sw_interface i_tdc_sw_interface (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.bus_add(bus_add),
		.bus_wdata(bus_wdata),
		.bus_wr(bus_wr),
		.bus_rd(bus_rd),
		.ext_en(ext_en),
		.ext_arm(ext_arm),
		.event_count(event_count),
		.miss_cnt(miss_cnt),
		.lost_cnt(lost_cnt),
		.bus_rdata(bus_rdata),
		.en_tdc(en_tdc),
		.en_arm_mode(en_arm_mode),
		.en_trig_distance(en_trig_distance),
		.en_write_timestamp(en_write_timestamp),
		.en_no_trig_err(en_no_trig_err),
		.inv_sig(inv_sig),
		.inv_trig(inv_trig),
		.arm_pulse(arm_pulse),
		.tdc_rst(tdc_rst)
	);

	tdc_input_timer i_tdc_input_timer (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.tdc_rst(tdc_rst),
		.tdc_in(tdc_in),
		.trig_in(trig_in),
		.inv_sig(inv_sig),
		.inv_trig(inv_trig),
		.timestamp(timestamp),
		.sig_rise(sig_rise),
		.sig_fall(sig_fall),
		.width_cnt(width_cnt),
		.trig_dist(trig_dist),
		.trig_seen(trig_seen),
		.ts_capture(ts_capture)
	);

	tdc_ctrl_fsm i_tdc_ctrl_fsm (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.tdc_rst(tdc_rst),
		.en_tdc(en_tdc),
		.en_arm_mode(en_arm_mode),
		.en_trig_distance(en_trig_distance),
		.en_write_timestamp(en_write_timestamp),
		.en_no_trig_err(en_no_trig_err),
		.arm_pulse(arm_pulse),
		.sig_rise(sig_rise),
		.sig_fall(sig_fall),
		.trig_seen(trig_seen),
		.word_valid(word_valid),
		.word_kind(word_kind),
		.event_done(event_done),
		.miss_pulse(miss_pulse)
	);

	tdc_word_builder i_tdc_word_builder (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.tdc_rst(tdc_rst),
		.word_valid(word_valid),
		.word_kind(word_kind),
		.event_done(event_done),
		.miss_pulse(miss_pulse),
		.width_cnt(width_cnt),
		.trig_dist(trig_dist),
		.ts_capture(ts_capture),
		.fifo_write(fifo_write),
		.fifo_wdata(fifo_wdata),
		.event_count(event_count),
		.miss_cnt(miss_cnt)
	);

	tdc_fifo i_tdc_fifo (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.tdc_rst(tdc_rst),
		.fifo_write(fifo_write),
		.fifo_wdata(fifo_wdata),
		.fifo_read(fifo_read),
		.fifo_data(fifo_data),
		.fifo_empty(fifo_empty),
		.lost_cnt(lost_cnt)
	);

endmodule

`default_nettype wire

// File: include/tdc_settings.svh
// --------------------------------------------------
// TDC settings
// identifier, version, FIFO size, bus decode, word
// field positions and configuration bit positions
// --------------------------------------------------
`ifndef TDC_SETTINGS_SVH
`define TDC_SETTINGS_SVH

`define TDC_DATA_IDENTIFIER 4'b0100
`define TDC_VERSION 8'd2
`define TDC_FIFO_DEPTH 16
`define TDC_FIFO_AW 4
`define TDC_ABUSWIDTH 16
`define TDC_BASEADDR 16'h0000

// output word fields
`define TDC_ID_MSB 31
`define TDC_ID_LSB 28
`define TDC_KIND_MSB 27
`define TDC_KIND_LSB 26
`define TDC_EVENT_MSB 25
`define TDC_EVENT_LSB 16
`define TDC_VALUE_MSB 15
`define TDC_VALUE_LSB 0

// configuration byte bits
`define TDC_CFG_EN 0
`define TDC_CFG_ARM 1
`define TDC_CFG_DIST 2
`define TDC_CFG_TS 3
`define TDC_CFG_INV_SIG 4
`define TDC_CFG_INV_TRIG 5
`define TDC_CFG_NO_TRIG_ERR 6

`endif

// File: test/tb_tdl_tdc.sv
// --------------------------------------------------
// TDC testbench
// directed tests of the register path, width,
// trigger distance, arm mode and FIFO overflow
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "tdc_settings.svh"

module tb_tdl_tdc;

	localparam int POP_TIMEOUT = 200;
	localparam logic [7:0] CFG_EN = 8'(1 << `TDC_CFG_EN);
	localparam logic [7:0] CFG_ARM = 8'(1 << `TDC_CFG_ARM);
	localparam logic [7:0] CFG_DIST = 8'(1 << `TDC_CFG_DIST);
	localparam logic [7:0] CFG_TS = 8'(1 << `TDC_CFG_TS);
	localparam logic [7:0] CFG_INV_SIG = 8'(1 << `TDC_CFG_INV_SIG);
	localparam logic [7:0] CFG_NO_TRIG = 8'(1 << `TDC_CFG_NO_TRIG_ERR);

	logic BUS_CLK;
	logic bus_clk_rst;
	logic [`TDC_ABUSWIDTH-1:0] bus_add;
	logic [7:0] bus_wdata;
	wire [7:0] bus_rdata;
	logic bus_wr;
	logic bus_rd;
	logic tdc_in;
	logic trig_in;
	logic [15:0] timestamp;
	logic ext_arm;
	logic ext_en;
	logic fifo_read;
	wire fifo_empty;
	wire [31:0] fifo_data;

	logic [31:0] rng_state;
	// event number the next measured pulse should carry
	logic [9:0] ev_next;

	tdl_tdc i_tdl_tdc (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.bus_add(bus_add),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.bus_wr(bus_wr),
		.bus_rd(bus_rd),
		.tdc_in(tdc_in),
		.trig_in(trig_in),
		.timestamp(timestamp),
		.ext_arm(ext_arm),
		.ext_en(ext_en),
		.fifo_read(fifo_read),
		.fifo_empty(fifo_empty),
		.fifo_data(fifo_data)
	);

	always begin
		BUS_CLK = 1'b0;
		#20;
		BUS_CLK = 1'b1;
		#20;
	end

	// --------------------------------------------------
	// reporting and compare tasks
	// --------------------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic value_mismatch(input string msg);
		abort_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
	endtask

	task automatic check_word(input logic [31:0] got, input tdc_pkg::tdc_word_kind_e kind,
		input logic [9:0] ev, input logic [15:0] value, input string what);
		logic [31:0] expected;
		// identifier, kind, event number, value from the top bit down
		expected = {`TDC_DATA_IDENTIFIER, kind, ev, value};
		if (got !== expected) begin
			value_mismatch($sformatf("%s: word %h, expected %h", what, got, expected));
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] expected,
		input string what);
		if (got !== expected) begin
			value_mismatch($sformatf("%s: read %h, expected %h", what, got, expected));
		end
	endtask

	task automatic check_count(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected) begin
			value_mismatch($sformatf("%s: count %0d, expected %0d", what, got, expected));
		end
	endtask

	task automatic check_flag(input logic got, input logic expected, input string what);
		if (got !== expected) begin
			value_mismatch($sformatf("%s: flag %b, expected %b", what, got, expected));
		end
	endtask

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// cycle counts between 2 and 40
	function automatic int rand_cycles();
		rng_state = xorshift32(rng_state);
		return 2 + int'(rng_state % 39);
	endfunction

	function automatic logic [15:0] rand_value();
		rng_state = xorshift32(rng_state);
		return rng_state[15:0];
	endfunction

	task automatic idle(input int n);
		repeat (n) @(posedge BUS_CLK);
		#2;
	endtask

	task automatic bus_write(input tdc_pkg::tdc_reg_e r, input logic [7:0] d);
		@(posedge BUS_CLK);
		#2;
		bus_add = `TDC_BASEADDR + 16'(r);
		bus_wdata = d;
		bus_wr = 1'b1;
		@(posedge BUS_CLK);
		#2;
		bus_wr = 1'b0;
	endtask

	task automatic bus_read(input tdc_pkg::tdc_reg_e r, output logic [7:0] d);
		@(posedge BUS_CLK);
		#2;
		bus_add = `TDC_BASEADDR + 16'(r);
		bus_rd = 1'b1;
		@(posedge BUS_CLK);
		#2;
		bus_rd = 1'b0;
		d = bus_rdata;
	endtask

	task automatic read_event_count(output logic [31:0] cnt);
		bus_read(tdc_pkg::REG_EVENT0, cnt[7:0]);
		bus_read(tdc_pkg::REG_EVENT1, cnt[15:8]);
		bus_read(tdc_pkg::REG_EVENT2, cnt[23:16]);
		bus_read(tdc_pkg::REG_EVENT3, cnt[31:24]);
	endtask

	// active level for n cycles and back to idle
	task automatic drive_pulse(input int n, input logic active_low);
		@(posedge BUS_CLK);
		#2;
		tdc_in = ~active_low;
		repeat (n) @(posedge BUS_CLK);
		#2;
		tdc_in = active_low;
	endtask

	// trigger rise lands d cycles before the rise of the following drive_pulse
	task automatic drive_trigger(input int d);
		@(posedge BUS_CLK);
		#2;
		trig_in = 1'b1;
		@(posedge BUS_CLK);
		#2;
		trig_in = 1'b0;
		repeat (d - 2) @(posedge BUS_CLK);
	endtask

	task automatic pop_word(output logic [31:0] w);
		int waited;
		waited = 0;
		@(posedge BUS_CLK);
		#2;
		while (fifo_empty) begin
			if (waited == POP_TIMEOUT) begin
				abort_run("timeout: no word arrived in the FIFO");
			end
			waited++;
			@(posedge BUS_CLK);
			#2;
		end
		w = fifo_data;
		fifo_read = 1'b1;
		@(posedge BUS_CLK);
		#2;
		fifo_read = 1'b0;
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_register_path();
		logic [7:0] d;
		logic [31:0] cnt;
		check_flag(fifo_empty, 1'b1, "FIFO empty after reset");
		bus_read(tdc_pkg::REG_VERSION, d);
		check_byte(d, `TDC_VERSION, "version register");
		bus_write(tdc_pkg::REG_CONFIG, 8'h4A);
		bus_read(tdc_pkg::REG_CONFIG, d);
		check_byte(d, 8'h4A, "config readback");
		bus_write(tdc_pkg::REG_CONFIG, 8'h00);
		read_event_count(cnt);
		check_count(cnt, 32'd0, "event count after reset");
		bus_read(tdc_pkg::REG_MISS, d);
		check_byte(d, 8'd0, "miss count after reset");
		bus_read(tdc_pkg::REG_LOST, d);
		check_byte(d, 8'd0, "lost count after reset");
	endtask

	task automatic test_width();
		int i;
		int n;
		logic [31:0] w;
		logic [31:0] cnt;
		bus_write(tdc_pkg::REG_CONFIG, CFG_EN);
		for (i = 0; i < 3; i++) begin
			n = rand_cycles();
			drive_pulse(n, 1'b0);
			pop_word(w);
			check_word(w, tdc_pkg::WORD_WIDTH, ev_next, 16'(n), "width word");
			ev_next++;
		end
		read_event_count(cnt);
		check_count(cnt, 32'd3, "event count after width pulses");
	endtask

	task automatic test_trigger_and_timestamp();
		int n;
		int d;
		logic [31:0] w;
		bus_write(tdc_pkg::REG_CONFIG, CFG_EN | CFG_DIST | CFG_TS);
		timestamp = rand_value();
		n = rand_cycles();
		d = rand_cycles();
		drive_trigger(d);
		drive_pulse(n, 1'b0);
		pop_word(w);
		check_word(w, tdc_pkg::WORD_TIMESTAMP, ev_next, timestamp, "timestamp word");
		pop_word(w);
		check_word(w, tdc_pkg::WORD_TRIG_DIST, ev_next, 16'(d), "distance word");
		pop_word(w);
		check_word(w, tdc_pkg::WORD_WIDTH, ev_next, 16'(n), "width after distance");
		ev_next++;
		// no trigger this time
		timestamp = rand_value();
		n = rand_cycles();
		drive_pulse(n, 1'b0);
		pop_word(w);
		check_word(w, tdc_pkg::WORD_TIMESTAMP, ev_next, timestamp, "second timestamp");
		pop_word(w);
		check_word(w, tdc_pkg::WORD_NO_TRIG, ev_next, 16'd0, "no-trigger word");
		pop_word(w);
		check_word(w, tdc_pkg::WORD_WIDTH, ev_next, 16'(n), "width after no trigger");
		ev_next++;
		bus_write(tdc_pkg::REG_CONFIG, CFG_EN | CFG_DIST | CFG_NO_TRIG);
		n = rand_cycles();
		drive_pulse(n, 1'b0);
		pop_word(w);
		check_word(w, tdc_pkg::WORD_WIDTH, ev_next, 16'(n), "width with suppress");
		ev_next++;
		idle(4);
		check_flag(fifo_empty, 1'b1, "no extra word with suppress");
		// idle level goes high before inversion is switched on
		bus_write(tdc_pkg::REG_CONFIG, 8'h00);
		tdc_in = 1'b1;
		idle(4);
		bus_write(tdc_pkg::REG_CONFIG, CFG_EN | CFG_INV_SIG);
		idle(4);
		n = rand_cycles();
		drive_pulse(n, 1'b1);
		pop_word(w);
		check_word(w, tdc_pkg::WORD_WIDTH, ev_next, 16'(n), "inverted width");
		ev_next++;
		bus_write(tdc_pkg::REG_CONFIG, 8'h00);
		idle(4);
		tdc_in = 1'b0;
		idle(4);
	endtask

	task automatic test_arm_mode();
		int n;
		logic [31:0] w;
		logic [31:0] cnt;
		logic [7:0] d;
		bus_write(tdc_pkg::REG_RESET, 8'h00);
		ev_next = '0;
		idle(2);
		bus_write(tdc_pkg::REG_CONFIG, CFG_EN | CFG_ARM);
		bus_write(tdc_pkg::REG_ARM, 8'h00);
		idle(2);
		n = rand_cycles();
		drive_pulse(n, 1'b0);
		pop_word(w);
		check_word(w, tdc_pkg::WORD_WIDTH, ev_next, 16'(n), "armed width");
		ev_next++;
		// these two arrive disarmed
		drive_pulse(rand_cycles(), 1'b0);
		idle(6);
		drive_pulse(rand_cycles(), 1'b0);
		idle(6);
		check_flag(fifo_empty, 1'b1, "no word while disarmed");
		bus_read(tdc_pkg::REG_MISS, d);
		check_byte(d, 8'd2, "miss count in arm mode");
		read_event_count(cnt);
		check_count(cnt, 32'd1, "event count in arm mode");
		@(posedge BUS_CLK);
		#2;
		ext_arm = 1'b1;
		@(posedge BUS_CLK);
		#2;
		ext_arm = 1'b0;
		idle(2);
		n = rand_cycles();
		drive_pulse(n, 1'b0);
		pop_word(w);
		check_word(w, tdc_pkg::WORD_WIDTH, ev_next, 16'(n), "width after ext_arm");
		ev_next++;
		bus_read(tdc_pkg::REG_MISS, d);
		check_byte(d, 8'd2, "miss count after ext_arm");
	endtask

	task automatic test_overflow_and_reset();
		int i;
		int n;
		int first;
		logic [31:0] cnt;
		logic [7:0] d;
		bus_write(tdc_pkg::REG_RESET, 8'h00);
		ev_next = '0;
		idle(2);
		// arm mode without an arm turns this pulse into a miss
		bus_write(tdc_pkg::REG_CONFIG, CFG_EN | CFG_ARM);
		drive_pulse(rand_cycles(), 1'b0);
		idle(6);
		bus_write(tdc_pkg::REG_CONFIG, CFG_EN);
		first = 0;
		for (i = 0; i < 20; i++) begin
			n = rand_cycles();
			if (i == 0) begin
				first = n;
			end
			drive_pulse(n, 1'b0);
			idle(6);
		end
		check_flag(fifo_empty, 1'b0, "FIFO holds words after overflow");
		check_word(fifo_data, tdc_pkg::WORD_WIDTH, 10'd0, 16'(first), "head after overflow");
		bus_read(tdc_pkg::REG_LOST, d);
		check_byte(d, 8'd4, "lost count after overflow");
		bus_read(tdc_pkg::REG_MISS, d);
		check_byte(d, 8'd1, "miss count before soft reset");
		read_event_count(cnt);
		check_count(cnt, 32'd20, "event count after overflow");
		bus_write(tdc_pkg::REG_RESET, 8'h00);
		idle(2);
		check_flag(fifo_empty, 1'b1, "FIFO empty after soft reset");
		read_event_count(cnt);
		check_count(cnt, 32'd0, "event count after soft reset");
		bus_read(tdc_pkg::REG_MISS, d);
		check_byte(d, 8'd0, "miss count after soft reset");
		bus_read(tdc_pkg::REG_LOST, d);
		check_byte(d, 8'd0, "lost count after soft reset");
	endtask

	initial begin
		rng_state = 32'h351b_8847;
		ev_next = '0;
		bus_clk_rst = 1'b1;
		bus_add = '0;
		bus_wdata = 8'd0;
		bus_wr = 1'b0;
		bus_rd = 1'b0;
		tdc_in = 1'b0;
		trig_in = 1'b0;
		timestamp = 16'd0;
		ext_arm = 1'b0;
		ext_en = 1'b0;
		fifo_read = 1'b0;
		repeat (5) @(posedge BUS_CLK);
		#2;
		bus_clk_rst = 1'b0;
		idle(2);
		test_register_path();
		test_width();
		test_trigger_and_timestamp();
		test_arm_mode();
		test_overflow_and_reset();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
